//--- compile.f
src/gpioPkg.sv
src/gpioCsr.sv
src/gpioBlinker.sv
src/usiReadJoin.sv
src/gpioTop.sv
test/gpioTbAssert.sv
test/gpioTb.sv

//--- test/gpioTb.sv
`timescale 1ns/100ps

module gpioTb;

	localparam int ClkPeriod   = 40;
	localparam int SeedValue   = 56557;
	localparam int WriteCount  = 8;
	localparam int BlinkPhases = 6;
	// Dividers 1, 3, 12, 0 on ch0 plus 3 on ch1
	localparam int BlinkDivSum = 20;
	// Reset, writes, decode, burst, blink runs, tail
	localparam int TestCycles  = 10 + WriteCount * 8 + 20 + 12 + BlinkPhases * BlinkDivSum
		+ 5 * 4 + 10;
	localparam int MarginCycles = 100;

	logic                             iSysClk;
	logic                             rstN;
	logic [gpioPkg::UsiDataWidth-1:0] usiWd;
	logic [gpioPkg::UsiAdrsWidth-1:0] usiAdrs;
	logic                             usiWCke;
	logic [gpioPkg::UsiDataWidth-1:0] usiRd;
	logic                             usiVd;
	logic [gpioPkg::PinWidth-1:0]     gpioPin0;
	logic [gpioPkg::PinWidth-1:0]     gpioPin1;
	int                               errCount;
	int                               testCount;

	gpioTop DUT (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.usiWd    (usiWd),
		.usiAdrs  (usiAdrs),
		.usiWCke  (usiWCke),
		.usiRd    (usiRd),
		.usiVd    (usiVd),
		.gpioPin0 (gpioPin0),
		.gpioPin1 (gpioPin1)
	);

	// Reference model and output checks
	gpioTbAssert uCheck (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.usiWd    (usiWd),
		.usiAdrs  (usiAdrs),
		.usiWCke  (usiWCke),
		.usiRd    (usiRd),
		.usiVd    (usiVd),
		.gpioPin0 (gpioPin0),
		.gpioPin1 (gpioPin1),
		.errCount (errCount)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever #(ClkPeriod / 2) iSysClk = ~iSysClk;
	end

	// Watchdog
	initial
	begin
		#(ClkPeriod * (TestCycles + MarginCycles));
		$display("Watchdog expired, tests did not finish in %0d cycles",
			TestCycles + MarginCycles);
		$display("*** FAILED ***");
		$finish;
	end

	//------------------------------------------------------------
	// Bus helpers
	//------------------------------------------------------------
	function automatic logic [31:0] makeAdrs(input logic [7:0] block, input logic [7:0] offset);
		logic [31:0] upper;
		// Random upper bits, ignored by decode
		upper = $urandom();
		return {upper[31:16], block, offset};
	endfunction

	function automatic logic [7:0] blockOf(input int ch);
		return (ch == 0) ? gpioPkg::BlockAdrsCh0 : gpioPkg::BlockAdrsCh1;
	endfunction

	// One bus cycle, then back to an unmapped idle address
	task automatic busCycle(input logic [31:0] adrs, input logic [31:0] data, input logic we);
		@(posedge iSysClk);
		usiAdrs <= adrs;
		usiWd   <= data;
		usiWCke <= we;
		@(posedge iSysClk);
		usiAdrs <= '0;
		usiWd   <= '0;
		usiWCke <= 1'b0;
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge iSysClk);
	endtask

	task automatic reportTest(input string name);
		testCount++;
		$display("Test %0d %s finished at %0t, errors so far %0d", testCount, name,
			$time, errCount);
	endtask

	// Blink write, then hold for six states
	task automatic blinkRun(input int ch, input logic [7:0] div);
		logic [31:0] data;
		int          effDiv;
		data = $urandom();
		data[gpioPkg::BlinkBit] = 1'b1;
		data[15:8] = div;
		if (data[7:0] == 8'h00)
			data[7:0] = 8'h5a;
		effDiv = (div == 8'h00) ? 1 : int'(div);
		busCycle(makeAdrs(blockOf(ch), gpioPkg::RegOffsetCtrl), data, 1'b1);
		waitCycles(effDiv * BlinkPhases + 2);
	endtask

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------
	initial
	begin
		logic [31:0] data;
		int          ch;
		void'($urandom(SeedValue));
		testCount = 0;
		rstN      = 1'b0;
		usiWd     = '0;
		usiAdrs   = '0;
		usiWCke   = 1'b0;
		repeat (2) @(posedge iSysClk);
		rstN <= 1'b1;
		waitCycles(3);
		reportTest("reset values");

		// Static mode, alternate channels
		for (int i = 0; i < WriteCount; i++)
		begin
			ch = i % 2;
			data = $urandom();
			data[gpioPkg::BlinkBit] = 1'b0;
			busCycle(makeAdrs(blockOf(ch), gpioPkg::RegOffsetCtrl), data, 1'b1);
			waitCycles(2);
			busCycle(makeAdrs(blockOf(ch), gpioPkg::RegOffsetCtrl), $urandom(), 1'b0);
			waitCycles(2);
		end
		reportTest("write and readback");

		// Writes that must be dropped
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh0, 8'h04), $urandom(), 1'b1);
		busCycle(makeAdrs(8'h07, gpioPkg::RegOffsetCtrl), $urandom(), 1'b1);
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh1, gpioPkg::RegOffsetCtrl), $urandom(), 1'b0);
		// Zero read, unmapped read, then both registers
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh1, 8'h10), '0, 1'b0);
		busCycle(makeAdrs(8'h33, gpioPkg::RegOffsetCtrl), '0, 1'b0);
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh0, gpioPkg::RegOffsetCtrl), '0, 1'b0);
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh1, gpioPkg::RegOffsetCtrl), '0, 1'b0);
		waitCycles(3);
		reportTest("decode rules");

		// Consecutive reads, channels interleaved
		for (int i = 0; i < 6; i++)
		begin
			@(posedge iSysClk);
			usiAdrs <= makeAdrs(blockOf(i % 2), gpioPkg::RegOffsetCtrl);
		end
		@(posedge iSysClk);
		usiAdrs <= '0;
		waitCycles(3);
		reportTest("back-to-back reads");

		blinkRun(0, 8'd1);
		blinkRun(0, 8'd3);
		blinkRun(0, 8'd12);
		blinkRun(0, 8'd0);
		blinkRun(1, 8'd3);
		// Both channels back to static
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh0, gpioPkg::RegOffsetCtrl), 32'h0000_05a5, 1'b1);
		busCycle(makeAdrs(gpioPkg::BlockAdrsCh1, gpioPkg::RegOffsetCtrl), 32'h0000_053c, 1'b1);
		waitCycles(3);
		reportTest("blink timing");

		$display("Tests run %0d, errors %0d", testCount, errCount);
		if (errCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- test/gpioTbAssert.sv
`timescale 1ns/100ps

module gpioTbAssert (
	// Clock and reset
	input  logic                             iSysClk,
	input  logic                             rstN,
	// Bus inputs of the DUT
	input  logic [gpioPkg::UsiDataWidth-1:0] usiWd,
	input  logic [gpioPkg::UsiAdrsWidth-1:0] usiAdrs,
	input  logic                             usiWCke,
	// DUT outputs under check
	input  logic [gpioPkg::UsiDataWidth-1:0] usiRd,
	input  logic                             usiVd,
	input  logic [gpioPkg::PinWidth-1:0]     gpioPin0,
	input  logic [gpioPkg::PinWidth-1:0]     gpioPin1,
	// Failed checks so far
	output int                               errCount
);

	// Register model per channel
	logic [gpioPkg::CtrlWidth-1:0]    regModel [gpioPkg::ChannelCount];
	// Write seen on the previous edge
	logic                             wrSeen [gpioPkg::ChannelCount];
	logic [gpioPkg::PinWidth-1:0]     pinExp [gpioPkg::ChannelCount];
	logic                             phaseExp [gpioPkg::ChannelCount];
	// Cycles left in the current blink state
	int                               holdLeft [gpioPkg::ChannelCount];
	// Two-stage read return model
	logic                             vdStage;
	logic                             vdExp;
	logic [gpioPkg::UsiDataWidth-1:0] rdStage;
	logic [gpioPkg::UsiDataWidth-1:0] rdExp;

	function automatic logic [gpioPkg::BlockAdrsWidth-1:0] blockOf(input int ch);
		return (ch == 0) ? gpioPkg::BlockAdrsCh0 : gpioPkg::BlockAdrsCh1;
	endfunction

	initial errCount = 0;

	//------------------------------------------------------------
	// Register and pin model
	//------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		logic wrHit;
		int   effDiv;
		for (int ch = 0; ch < gpioPkg::ChannelCount; ch++)
		begin
			// Strobe, block and offset must all match
			wrHit = usiWCke && usiAdrs[15:8] == blockOf(ch) &&
				usiAdrs[7:0] == gpioPkg::RegOffsetCtrl;
			effDiv = (regModel[ch][15:8] == 0) ? 1 : int'(regModel[ch][15:8]);
			if (!rstN)
			begin
				regModel[ch] <= {1'b0, gpioPkg::DivResetValue, gpioPkg::LedResetValue};
				wrSeen[ch]   <= 1'b0;
				pinExp[ch]   <= gpioPkg::LedResetValue;
				phaseExp[ch] <= 1'b1;
				holdLeft[ch] <= 0;
			end
			else
			begin
				wrSeen[ch] <= wrHit;
				if (wrHit)
				begin
					regModel[ch] <= usiWd[gpioPkg::CtrlWidth-1:0];
				end
				// Fresh write or static mode shows the mask
				if (wrSeen[ch] || !regModel[ch][16])
				begin
					pinExp[ch]   <= regModel[ch][7:0];
					phaseExp[ch] <= 1'b1;
					holdLeft[ch] <= effDiv - 1;
				end
				else if (holdLeft[ch] == 0)
				begin
					// State used up, flip between mask and dark
					pinExp[ch]   <= phaseExp[ch] ? '0 : regModel[ch][7:0];
					phaseExp[ch] <= !phaseExp[ch];
					holdLeft[ch] <= effDiv - 1;
				end
				else
				begin
					holdLeft[ch] <= holdLeft[ch] - 1;
				end
			end
		end
	end

	//------------------------------------------------------------
	// Read return model
	//------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		logic                             hitAny;
		logic [gpioPkg::UsiDataWidth-1:0] rdNext;
		hitAny = 1'b0;
		rdNext = '0;
		for (int ch = 0; ch < gpioPkg::ChannelCount; ch++)
		begin
			if (usiAdrs[15:8] == blockOf(ch))
			begin
				// Valid on any block hit, data only on the control offset
				hitAny = 1'b1;
				if (usiAdrs[7:0] == gpioPkg::RegOffsetCtrl)
				begin
					rdNext = {{(gpioPkg::UsiDataWidth-gpioPkg::CtrlWidth){1'b0}}, regModel[ch]};
				end
			end
		end
		if (!rstN)
		begin
			vdStage <= 1'b0;
			rdStage <= '0;
			vdExp   <= 1'b0;
			rdExp   <= '0;
		end
		else
		begin
			vdStage <= hitAny;
			rdStage <= rdNext;
			vdExp   <= vdStage;
			rdExp   <= rdStage;
		end
	end

	//------------------------------------------------------------
	// Checks on the DUT outputs
	//------------------------------------------------------------
	aUsiVd: assert property (@(posedge iSysClk) disable iff (!rstN) usiVd == vdExp)
	else
	begin
		$display("Error at %0t: usiVd expected %0b actual %0b", $time,
			$sampled(vdExp), $sampled(usiVd));
		errCount++;
	end

	aUsiRd: assert property (@(posedge iSysClk) disable iff (!rstN) usiRd == rdExp)
	else
	begin
		$display("Error at %0t: usiRd expected %h actual %h", $time,
			$sampled(rdExp), $sampled(usiRd));
		errCount++;
	end

	aPin0: assert property (@(posedge iSysClk) disable iff (!rstN) gpioPin0 == pinExp[0])
	else
	begin
		$display("Error at %0t: gpioPin0 expected %h actual %h", $time,
			$sampled(pinExp[0]), $sampled(gpioPin0));
		errCount++;
	end

	aPin1: assert property (@(posedge iSysClk) disable iff (!rstN) gpioPin1 == pinExp[1])
	else
	begin
		$display("Error at %0t: gpioPin1 expected %h actual %h", $time,
			$sampled(pinExp[1]), $sampled(gpioPin1));
		errCount++;
	end

endmodule

//--- src/gpioTop.sv
`timescale 1ns/100ps

module gpioTop (
	// Clock and reset
	input  logic                             iSysClk,
	input  logic                             rstN,
	// USI bus from the master
	input  logic [gpioPkg::UsiDataWidth-1:0] usiWd,
	input  logic [gpioPkg::UsiAdrsWidth-1:0] usiAdrs,
	input  logic                             usiWCke,
	// Registered read return
	output logic [gpioPkg::UsiDataWidth-1:0] usiRd,
	output logic                             usiVd,
	// Pin groups
	output logic [gpioPkg::PinWidth-1:0]     gpioPin0,
	output logic [gpioPkg::PinWidth-1:0]     gpioPin1
);

	// Read returns per channel
	logic [gpioPkg::UsiDataWidth-1:0] chRd [gpioPkg::ChannelCount];
	logic                             chVd [gpioPkg::ChannelCount];

	// Channel 0 register fields
	logic [gpioPkg::PinWidth-1:0]     ledMask0;
	logic [gpioPkg::DivWidth-1:0]     blinkDiv0;
	logic                             blinkEn0;
	logic                             cfgWrite0;

	// Channel 1 register fields
	logic [gpioPkg::PinWidth-1:0]     ledMask1;
	logic [gpioPkg::DivWidth-1:0]     blinkDiv1;
	logic                             blinkEn1;
	logic                             cfgWrite1;

	//------------------------------------------------------------
	// Channel 0
	//------------------------------------------------------------
	gpioCsr #(
		.pBlockAdrs (gpioPkg::BlockAdrsCh0)
	) uCsr0 (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.usiWd    (usiWd),
		.usiAdrs  (usiAdrs),
		.usiWCke  (usiWCke),
		.csrRd    (chRd[0]),
		.csrVd    (chVd[0]),
		.ledMask  (ledMask0),
		.blinkDiv (blinkDiv0),
		.blinkEn  (blinkEn0),
		.cfgWrite (cfgWrite0)
	);

	gpioBlinker uBlink0 (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.ledMask  (ledMask0),
		.blinkDiv (blinkDiv0),
		.blinkEn  (blinkEn0),
		.cfgWrite (cfgWrite0),
		.gpioPin  (gpioPin0)
	);

	//------------------------------------------------------------
	// Channel 1
	//------------------------------------------------------------
	gpioCsr #(
		.pBlockAdrs (gpioPkg::BlockAdrsCh1)
	) uCsr1 (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.usiWd    (usiWd),
		.usiAdrs  (usiAdrs),
		.usiWCke  (usiWCke),
		.csrRd    (chRd[1]),
		.csrVd    (chVd[1]),
		.ledMask  (ledMask1),
		.blinkDiv (blinkDiv1),
		.blinkEn  (blinkEn1),
		.cfgWrite (cfgWrite1)
	);

	gpioBlinker uBlink1 (
		.iSysClk  (iSysClk),
		.rstN     (rstN),
		.ledMask  (ledMask1),
		.blinkDiv (blinkDiv1),
		.blinkEn  (blinkEn1),
		.cfgWrite (cfgWrite1),
		.gpioPin  (gpioPin1)
	);

	// Read returns merged onto the bus
	usiReadJoin uJoin (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.chRd    (chRd),
		.chVd    (chVd),
		.usiRd   (usiRd),
		.usiVd   (usiVd)
	);

endmodule

//--- src/usiReadJoin.sv
`timescale 1ns/100ps

module usiReadJoin (
	// Clock and reset
	input  logic                             iSysClk,
	input  logic                             rstN,
	// Per-channel read returns
	input  logic [gpioPkg::UsiDataWidth-1:0] chRd [gpioPkg::ChannelCount],
	input  logic                             chVd [gpioPkg::ChannelCount],
	// Merged return to the bus
	output logic [gpioPkg::UsiDataWidth-1:0] usiRd,
	output logic                             usiVd
);

	logic [gpioPkg::ChannelCount-1:0] vdVec;
	logic [gpioPkg::UsiDataWidth-1:0] selRd;

	//------------------------------------------------------------
	// Select
	//------------------------------------------------------------

	// AND-OR mux, zero when nobody is valid
	always_comb
	begin
		vdVec = '0;
		selRd = '0;
		for (int i = 0; i < gpioPkg::ChannelCount; i++)
		begin
			vdVec[i] = chVd[i];
			if (chVd[i])
			begin
				selRd = selRd | chRd[i];
			end
		end
	end

	//------------------------------------------------------------
	// Return register
	//------------------------------------------------------------

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			usiRd <= '0;
			usiVd <= 1'b0;
		end
		else
		begin
			usiRd <= selRd;
			// Any channel hit gives one bus valid
			usiVd <= |vdVec;
		end
	end

	// Block addresses are disjoint across channels
	aOneChannel: assert property (@(posedge iSysClk) disable iff (!rstN)
		$onehot0(vdVec));

endmodule

//--- src/gpioBlinker.sv
`timescale 1ns/100ps

module gpioBlinker (
	// Clock and reset
	input  logic                         iSysClk,
	input  logic                         rstN,
	// Register fields from the CSR
	input  logic [gpioPkg::PinWidth-1:0] ledMask,
	input  logic [gpioPkg::DivWidth-1:0] blinkDiv,
	input  logic                         blinkEn,
	input  logic                         cfgWrite,
	// Pin group
	output logic [gpioPkg::PinWidth-1:0] gpioPin
);

	logic [gpioPkg::DivWidth-1:0] effDiv;
	logic [gpioPkg::DivWidth-1:0] preCnt;
	logic                         cntWrap;
	logic                         phaseOn;
	logic                         phaseNext;

	//------------------------------------------------------------
	// Prescaler
	//------------------------------------------------------------

	// Divider of zero acts as one
	assign effDiv = (blinkDiv == '0) ? {{(gpioPkg::DivWidth-1){1'b0}}, 1'b1} : blinkDiv;

	// Last count of the current phase
	assign cntWrap = preCnt == effDiv - 1'b1;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			preCnt <= '0;
		end
		else if (cfgWrite || !blinkEn || cntWrap)
		begin
			// Restart on any write, idle while blink is off
			preCnt <= '0;
		end
		else
		begin
			preCnt <= preCnt + 1'b1;
		end
	end

	//------------------------------------------------------------
	// Phase and pin register
	//------------------------------------------------------------

	// Phase for the coming cycle
	// Write forces on so the first state shows the mask
	always_comb
	begin
		if (cfgWrite || !blinkEn)
		begin
			phaseNext = 1'b1;
		end
		else if (cntWrap)
		begin
			phaseNext = !phaseOn;
		end
		else
		begin
			phaseNext = phaseOn;
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			phaseOn <= 1'b1;
			gpioPin <= gpioPkg::LedResetValue;
		end
		else
		begin
			phaseOn <= phaseNext;
			// Pins track the phase they load with
			gpioPin <= phaseNext ? ledMask : '0;
		end
	end

	// Divider only moves together with cfgWrite
	aCntBelowDiv: assert property (@(posedge iSysClk) disable iff (!rstN)
		!cfgWrite |-> preCnt < effDiv);

endmodule

//--- src/gpioCsr.sv
`timescale 1ns/100ps

module gpioCsr #(
	// Value matched against address bits 15:8
	parameter logic [gpioPkg::BlockAdrsWidth-1:0] pBlockAdrs = gpioPkg::BlockAdrsCh0
)(
	// Clock and reset
	input  logic                             iSysClk,
	input  logic                             rstN,
	// USI write side
	input  logic [gpioPkg::UsiDataWidth-1:0] usiWd,
	input  logic [gpioPkg::UsiAdrsWidth-1:0] usiAdrs,
	input  logic                             usiWCke,
	// Read return toward the join stage
	output logic [gpioPkg::UsiDataWidth-1:0] csrRd,
	output logic                             csrVd,
	// Register fields toward the blinker
	output logic [gpioPkg::PinWidth-1:0]     ledMask,
	output logic [gpioPkg::DivWidth-1:0]     blinkDiv,
	output logic                             blinkEn,
	// Restart pulse for the blinker
	output logic                             cfgWrite
);

	logic                             blockHit;
	logic                             offsetHit;
	logic                             wrHit;
	logic [gpioPkg::CtrlWidth-1:0]    ctrlReg;
	logic [gpioPkg::UsiDataWidth-1:0] rdData;

	//------------------------------------------------------------
	// Address decode
	//------------------------------------------------------------

	// Block field above the offset
	assign blockHit =
		usiAdrs[gpioPkg::BlockAdrsLsb +: gpioPkg::BlockAdrsWidth] == pBlockAdrs;

	// Offset within the block
	assign offsetHit =
		usiAdrs[gpioPkg::RegOffsetWidth-1:0] == gpioPkg::RegOffsetCtrl;

	// Write needs strobe, block and offset together
	// Upper address bits are don't care
	assign wrHit = usiWCke & blockHit & offsetHit;

	//------------------------------------------------------------
	// Control register
	//------------------------------------------------------------

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			// Blink off, default divider, LEDs on
			ctrlReg  <= {1'b0, gpioPkg::DivResetValue, gpioPkg::LedResetValue};
			cfgWrite <= 1'b0;
		end
		else
		begin
			if (wrHit)
			begin
				// Only the low 17 bits are stored
				ctrlReg <= usiWd[gpioPkg::CtrlWidth-1:0];
			end
			// Pulse lands with the new field values
			cfgWrite <= wrHit;
		end
	end

	// Field split
	assign ledMask  = ctrlReg[gpioPkg::LedLsb +: gpioPkg::PinWidth];
	assign blinkDiv = ctrlReg[gpioPkg::DivLsb +: gpioPkg::DivWidth];
	assign blinkEn  = ctrlReg[gpioPkg::BlinkBit];

	//------------------------------------------------------------
	// Read return
	//------------------------------------------------------------

	// Zero-extended register on the control offset
	// Anything else in the block reads as zero
	always_comb
	begin
		rdData = '0;
		if (blockHit && offsetHit)
		begin
			rdData[gpioPkg::CtrlWidth-1:0] = ctrlReg;
		end
	end

	// Valid follows any block hit, write strobe or not
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			csrVd <= 1'b0;
		end
		else
		begin
			csrVd <= blockHit;
		end
	end

	// Registered read data
	always_ff @(posedge iSysClk)
	begin
		csrRd <= rdData;
	end

endmodule

//--- src/gpioPkg.sv
package gpioPkg;

//------------------------------------------------------------
// USI bus widths
//------------------------------------------------------------
	localparam int UsiAdrsWidth = 32;
	localparam int UsiDataWidth = 32;

	// Channels hanging off the bus
	localparam int ChannelCount = 2;

//------------------------------------------------------------
// Address map
//------------------------------------------------------------
	// Block select lives in address bits 15:8
	localparam int BlockAdrsLsb   = 8;
	localparam int BlockAdrsWidth = 8;
	// Register offset in address bits 7:0
	localparam int RegOffsetWidth = 8;

	localparam logic [BlockAdrsWidth-1:0] BlockAdrsCh0 = 8'h01;
	localparam logic [BlockAdrsWidth-1:0] BlockAdrsCh1 = 8'h02;

	// Only one register per block
	localparam logic [RegOffsetWidth-1:0] RegOffsetCtrl = 8'h00;

//------------------------------------------------------------
// Control register layout
//------------------------------------------------------------
	// One pin group per channel
	localparam int PinWidth = 8;
	localparam int DivWidth = 8;

	// Field positions
	localparam int LedLsb   = 0;
	localparam int DivLsb   = 8;
	localparam int BlinkBit = 16;
	// LED mask, divider and blink enable
	localparam int CtrlWidth = BlinkBit + 1;

	// All LEDs on out of reset
	localparam logic [PinWidth-1:0] LedResetValue = 8'hff;
	// Default blink prescale
	localparam logic [DivWidth-1:0] DivResetValue = 8'h05;

endpackage
